/* mips_core.f */
+incdir+tb
verilog/mips_pkg.sv
verilog/register_file.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_stage.sv
verilog/mips_core_top.sv
tb/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the MIPS core testbench
# Passes only when the simulation output holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mips_core -Mdir obj_dir -f mips_core.f \
    && ./obj_dir/Vtb_mips_core | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

/* tb/tb_mips_model.svh */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// Architectural registers as of issue, in program order
logic [DATA_W-1:0] model_regs [NUM_REGS];

// Expected retire records, oldest first
wb_t exp_q [$];

function automatic logic [INSTR_W-1:0] enc_rtype(input logic [4:0] rs, rt, rd, sh,
                                                 input logic [5:0] fn);
    return {OPC_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic logic [INSTR_W-1:0] enc_itype(input logic [5:0] opc,
                                                 input logic [4:0] rs, rt,
                                                 input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

// Result of one instruction against model_regs
// Returns 0 for an encoding that never retires
function automatic logic expect_result(
    input  logic [INSTR_W-1:0]    ins,
    output logic [REG_ADDR_W-1:0] dest,
    output logic [DATA_W-1:0]     data
);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [15:0]       imm;
    logic              ok;
    a    = model_regs[ins[25:21]];
    b    = model_regs[ins[20:16]];
    imm  = ins[15:0];
    dest = ins[20:16];
    data = '0;
    ok   = 1'b1;
    case (ins[31:26])
        OPC_RTYPE:
        begin
            dest = ins[15:11];
            case (ins[5:0])
                FN_ADD:  data = a + b;
                FN_SUB:  data = a - b;
                FN_AND:  data = a & b;
                FN_OR:   data = a | b;
                FN_XOR:  data = a ^ b;
                // Signed compare
                FN_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLL:  data = b << ins[10:6];
                FN_SRL:  data = b >> ins[10:6];
                default: ok = 1'b0;
            endcase
        end
        OPC_ADDI: data = a + {{16{imm[15]}}, imm};
        OPC_ANDI: data = a & {16'h0000, imm};
        OPC_ORI:  data = a | {16'h0000, imm};
        OPC_XORI: data = a ^ {16'h0000, imm};
        OPC_LUI:  data = {imm, 16'h0000};
        default:  ok = 1'b0;
    endcase
    // Register 0 always holds zero
    if (dest == '0)
        data = '0;
    return ok;
endfunction

// Steps the model by one issued instruction
function automatic void model_issue(input logic [INSTR_W-1:0] ins);
    logic [REG_ADDR_W-1:0] d;
    logic [DATA_W-1:0]     v;
    wb_t                   rec;
    if (expect_result(ins, d, v))
    begin
        rec.valid = 1'b1;
        rec.dest  = d;
        rec.data  = v;
        exp_q.push_back(rec);
        model_regs[d] = v;
    end
endfunction

`endif

/* tb/tb_mips_core.sv */
`timescale 1ns/1ns

module tb_mips_core
    import mips_pkg::*;
();

    localparam int NUM_INSTR        = 300;
    localparam int NUM_DBG_PHASES   = 6;
    localparam int DBG_PHASE_CYCLES = 40;
    // Bound on the whole run in clock cycles
    localparam int TIMEOUT_CYCLES   =
        4 * (NUM_INSTR + NUM_DBG_PHASES * DBG_PHASE_CYCLES) + 100;

    // DUT ports
    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic [INSTR_W-1:0]    instr;
    logic                  instr_credit;
    wb_t                   retire;
    logic                  dbg_on;
    logic [REG_ADDR_W-1:0] dbg_addr;
    logic [DATA_W-1:0]     dbg_data;

    // Source and checker state
    logic [31:0]           rng_state;
    int                    credits;
    int                    dbg_age;
    int                    cycle_count;
    logic                  read_pending;
    logic [REG_ADDR_W-1:0] read_addr;
    logic [REG_ADDR_W-1:0] last_dest;
    logic                  dbg_on_d;
    // Register contents as retired so far
    logic [DATA_W-1:0]     commit_regs [NUM_REGS];

    `include "tb_mips_model.svh"

    mips_core_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .retire       (retire),
        .dbg_on       (dbg_on),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data)
    );

    ////////////////////////////////////////////////////////////
    // Clock, timeout, frozen-issue property
    ////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_failure("Timeout: the run did not finish within the cycle limit");
    end

    // Debug mode one cycle earlier
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dbg_on_d <= 1'b0;
        else
            dbg_on_d <= dbg_on;
    end

    // No credit comes back once issue is held
    assert property (@(posedge clk) disable iff (rst) !(dbg_on && dbg_on_d && instr_credit))
        else report_failure("Credit pulse while debug mode held issue");

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first failure");
    endtask

    // xorshift32
    function automatic logic [31:0] rand_next();
        logic [31:0] x;
        x         = rng_state;
        x         = x ^ (x << 13);
        x         = x ^ (x >> 17);
        x         = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Favors a few registers so that dependencies repeat
    function automatic logic [REG_ADDR_W-1:0] pick_reg();
        logic [31:0] r;
        r = rand_next();
        if (r[3:0] == 4'd0)
            return '0;
        else if (r[4])
            return {2'b00, r[7:5]};
        else
            return r[12:8];
    endfunction

    task automatic pick_instruction(output logic [INSTR_W-1:0] ins);
        logic [31:0]           r;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        r  = rand_next();
        rs = pick_reg();
        rt = pick_reg();
        rd = pick_reg();
        // Mostly chain on the previous destination
        if (r[5:4] != 2'b00)
            rs = last_dest;
        if (r[7:6] == 2'b00)
            rt = last_dest;
        case (r[3:0])
            4'd0:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_ADD);
            4'd1:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_SUB);
            4'd2:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_AND);
            4'd3:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_OR);
            4'd4:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_XOR);
            4'd5:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_SLT);
            4'd6:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_SLL);
            4'd7:    ins = enc_rtype(rs, rt, rd, r[12:8], FN_SRL);
            4'd8:    ins = enc_itype(OPC_ADDI, rs, rt, r[31:16]);
            4'd9:    ins = enc_itype(OPC_ANDI, rs, rt, r[31:16]);
            4'd10:   ins = enc_itype(OPC_ORI, rs, rt, r[31:16]);
            4'd11:   ins = enc_itype(OPC_XORI, rs, rt, r[31:16]);
            4'd12:   ins = enc_itype(OPC_LUI, rs, rt, r[31:16]);
            4'd13:   ins = enc_itype(OPC_ADDI, rs, rt, r[31:16]);
            // Undecodable, a load opcode and an unsigned add
            4'd14:   ins = enc_itype(6'h23, rs, rt, r[31:16]);
            default: ins = enc_rtype(rs, rt, rd, r[12:8], 6'h21);
        endcase
        if (r[3:0] <= 4'd7)
            last_dest = rd;
        else if (r[3:0] <= 4'd13)
            last_dest = rt;
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle checks, at the falling edge
    ////////////////////////////////////////////////////////////

    task automatic observe_outputs();
        wb_t exp;
        if (dbg_on)
            dbg_age = dbg_age + 1;
        else
            dbg_age = 0;
        // Credits back to the source
        if (instr_credit)
        begin
            credits = credits + 1;
            assert (credits <= INSTR_BUF_DEPTH)
                else report_failure("More credits returned than entries in the buffer");
            assert (dbg_age <= 1)
                else report_failure("Credit returned while issue was frozen");
        end
        // In-order retire against the model
        if (retire.valid)
        begin
            assert (dbg_age <= 3)
                else report_failure("Retire more than 3 cycles after debug mode began");
            assert (exp_q.size() != 0)
                else report_failure("Retire seen with no instruction outstanding");
            exp = exp_q.pop_front();
            assert (retire.dest == exp.dest)
                else report_failure($sformatf("ERROR: retire.dest expected %h, seen %h",
                                              exp.dest, retire.dest));
            assert (retire.data == exp.data)
                else report_failure($sformatf("ERROR: retire.data expected %h, seen %h",
                                              exp.data, retire.data));
            commit_regs[exp.dest] = exp.data;
        end
        // Debug read issued one cycle ago
        if (read_pending)
        begin
            assert (dbg_data == commit_regs[read_addr])
                else report_failure($sformatf("ERROR: dbg_data expected %h, seen %h (r%0d)",
                                              commit_regs[read_addr], dbg_data, read_addr));
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        observe_outputs();
    endtask

    task automatic idle_cycle();
        instr_valid = 1'b0;
        next_cycle();
    endtask

    // One valid cycle, only with a credit in hand
    task automatic send_instruction(input logic [INSTR_W-1:0] ins);
        while (credits == 0)
            idle_cycle();
        instr_valid = 1'b1;
        instr       = ins;
        credits     = credits - 1;
        model_issue(ins);
        next_cycle();
        instr_valid = 1'b0;
    endtask

    // Freeze, let popped work drain, then read every register
    task automatic run_debug_phase();
        instr_valid = 1'b0;
        dbg_on      = 1'b1;
        repeat (4)
            next_cycle();
        for (int a = 0; a < NUM_REGS; a++)
        begin
            dbg_addr     = REG_ADDR_W'(a);
            read_addr    = REG_ADDR_W'(a);
            read_pending = 1'b1;
            next_cycle();
        end
        read_pending = 1'b0;
        dbg_on       = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [INSTR_W-1:0] ins;
        logic [31:0]        r;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        dbg_on       = 1'b0;
        dbg_addr     = '0;
        rng_state    = 32'd47881;
        credits      = INSTR_BUF_DEPTH;
        dbg_age      = 0;
        cycle_count  = 0;
        read_pending = 1'b0;
        read_addr    = '0;
        last_dest    = '0;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            model_regs[i]  = '0;
            commit_regs[i] = '0;
        end
        repeat (5)
            @(negedge clk);
        rst = 1'b0;
        // All registers zero out of reset
        run_debug_phase();
        for (int n = 1; n <= NUM_INSTR; n++)
        begin
            pick_instruction(ins);
            send_instruction(ins);
            r = rand_next();
            // Occasional gap in the stream
            if (r[1:0] == 2'b00)
                idle_cycle();
            // Freeze with work still in flight
            if ((n % 60 == 0) && (n != NUM_INSTR))
                run_debug_phase();
        end
        // Drain until every expected retire has been seen
        while (exp_q.size() != 0)
            idle_cycle();
        // Trailing undecodable entries still pop and hand back credits
        repeat (INSTR_BUF_DEPTH + 4)
            idle_cycle();
        assert (credits == INSTR_BUF_DEPTH)
            else report_failure($sformatf("ERROR: credits expected %h, seen %h",
                                          INSTR_BUF_DEPTH, credits));
        run_debug_phase();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* verilog/mips_core_top.sv */
`timescale 1ns/1ns

module mips_core_top
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Instruction port
    input  logic                  instr_valid,
    input  logic [INSTR_W-1:0]    instr,
    output logic                  instr_credit,
    // Retire port
    output wb_t                   retire,
    // Debug port
    input  logic                  dbg_on,
    input  logic [REG_ADDR_W-1:0] dbg_addr,
    output logic [DATA_W-1:0]     dbg_data
);

    // Register file read path
    logic [REG_ADDR_W-1:0] rf_raddr_a;
    logic [REG_ADDR_W-1:0] rf_raddr_b;
    logic [DATA_W-1:0]     rf_rdata_a;
    logic [DATA_W-1:0]     rf_rdata_b;

    // Register file write path
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [DATA_W-1:0]     rf_wdata;

    // Stage registers
    dec_op_t               dec_op;
    wb_t                   exe_wb;
    wb_t                   res_wb;

    ////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////

    instr_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .dbg_on       (dbg_on),
        .raddr_a      (rf_raddr_a),
        .raddr_b      (rf_raddr_b),
        .rdata_a      (rf_rdata_a),
        .rdata_b      (rf_rdata_b),
        .exe_fwd      (exe_wb),
        .res_fwd      (res_wb),
        .dec_out      (dec_op)
    );

    alu_execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .dec_in  (dec_op),
        .exe_out (exe_wb)
    );

    result_stage u_result (
        .clk     (clk),
        .rst     (rst),
        .exe_in  (exe_wb),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .res_out (res_wb)
    );

    // Retired instructions leave straight from the result register
    assign retire = res_wb;

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    register_file u_regfile (
        .clk      (clk),
        .rst      (rst),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .raddr_a  (rf_raddr_a),
        .raddr_b  (rf_raddr_b),
        .rdata_a  (rf_rdata_a),
        .rdata_b  (rf_rdata_b),
        .dbg_on   (dbg_on),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

/* verilog/result_stage.sv */
`timescale 1ns/1ns

module result_stage
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  wb_t                   exe_in,
    // Register file write
    output logic                  we,
    output logic [REG_ADDR_W-1:0] waddr,
    output logic [DATA_W-1:0]     wdata,
    // Retire record and second forwarding source
    output wb_t                   res_out
);

    wb_t res_next;

    ////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////

    // Register 0 holds zero whatever was computed
    always_comb
    begin
        res_next = exe_in;
        if (exe_in.dest == '0)
            res_next.data = '0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            res_out <= '0;
        else
            res_out <= res_next;
    end

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    // Write lands one edge after the register loads
    // Decode covers that cycle through res_out
    assign we    = res_out.valid;
    assign waddr = res_out.dest;
    assign wdata = res_out.data;

endmodule

/* verilog/alu_execute.sv */
`timescale 1ns/1ns

module alu_execute
    import mips_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  dec_op_t dec_in,
    output wb_t     exe_out
);

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_res;
    logic              slt_bit;

    ////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////

    // exe_out still holds the previous instruction
    // Decode flags when that one is the producer
    assign op_a = dec_in.fwd_a ? exe_out.data : dec_in.operand_a;
    assign op_b = dec_in.fwd_b ? exe_out.data : dec_in.operand_b;

    // Signed compare for SLT
    assign slt_bit = $signed(op_a) < $signed(op_b);

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (dec_in.op)
            ALU_ADD:
                alu_res = op_a + op_b;
            ALU_SUB:
                alu_res = op_a - op_b;
            ALU_AND:
                alu_res = op_a & op_b;
            ALU_OR:
                alu_res = op_a | op_b;
            ALU_XOR:
                alu_res = op_a ^ op_b;
            ALU_SLT:
                alu_res = {{(DATA_W - 1){1'b0}}, slt_bit};
            // Shifts act on rt
            ALU_SLL:
                alu_res = op_b << dec_in.shamt;
            ALU_SRL:
                alu_res = op_b >> dec_in.shamt;
            // Immediate into the upper half
            ALU_LUI:
                alu_res = {op_b[15:0], 16'h0000};
            default:
                alu_res = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Execute register
    ////////////////////////////////////////////////////////////

    // Also the first forwarding source for decode
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exe_out <= '0;
        end
        else
        begin
            exe_out.valid <= dec_in.valid;
            exe_out.dest  <= dec_in.dest;
            exe_out.data  <= alu_res;
        end
    end

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Credit-based instruction port
    input  logic                  instr_valid,
    input  logic [INSTR_W-1:0]    instr,
    output logic                  instr_credit,
    // Issue freeze
    input  logic                  dbg_on,
    // Register file reads
    output logic [REG_ADDR_W-1:0] raddr_a,
    output logic [REG_ADDR_W-1:0] raddr_b,
    input  logic [DATA_W-1:0]     rdata_a,
    input  logic [DATA_W-1:0]     rdata_b,
    // Forwarding from later stages
    input  wb_t                   exe_fwd,
    input  wb_t                   res_fwd,
    output dec_op_t               dec_out
);

    logic [INSTR_W-1:0]      instr_buf [INSTR_BUF_DEPTH];
    logic [BUF_PTR_W-1:0]    wr_ptr;
    logic [BUF_PTR_W-1:0]    rd_ptr;
    logic [CREDIT_CNT_W-1:0] buf_count;
    logic                    pop;
    logic [INSTR_W-1:0]      head;
    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic [4:0]              rs;
    logic [4:0]              rt;
    logic [4:0]              rd;
    logic [4:0]              shamt;
    logic [15:0]             imm;
    logic                    legal;
    alu_op_e                 op;
    logic [REG_ADDR_W-1:0]   dest;
    logic                    use_imm;
    logic [DATA_W-1:0]       imm_ext;
    dec_op_t                 dec_next;

    // Youngest first: execute register, then result register, then the array
    function automatic logic [DATA_W-1:0] fwd_pick(
        input logic [REG_ADDR_W-1:0] src,
        input logic [DATA_W-1:0]     rf_val,
        input wb_t                   exe_w,
        input wb_t                   res_w
    );
        logic [DATA_W-1:0] val;
        val = rf_val;
        if (res_w.valid && (res_w.dest != '0) && (res_w.dest == src))
            val = res_w.data;
        if (exe_w.valid && (exe_w.dest != '0) && (exe_w.dest == src))
            val = exe_w.data;
        return val;
    endfunction

    ////////////////////////////////////////////////////////////
    // Instruction buffer
    ////////////////////////////////////////////////////////////

    // One pop per cycle unless empty or frozen
    assign pop  = (buf_count != '0) && !dbg_on;
    assign head = instr_buf[rd_ptr];

    // Entry storage, space guaranteed by the credits
    always_ff @(posedge clk)
    begin
        if (instr_valid)
            instr_buf[wr_ptr] <= instr;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            buf_count    <= '0;
            instr_credit <= 1'b0;
        end
        else
        begin
            if (instr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            buf_count    <= buf_count + CREDIT_CNT_W'(instr_valid) - CREDIT_CNT_W'(pop);
            // One credit back per freed entry
            instr_credit <= pop;
        end
    end

    ////////////////////////////////////////////////////////////
    // Field split and decode
    ////////////////////////////////////////////////////////////

    assign opcode = head[31:26];
    assign rs     = head[25:21];
    assign rt     = head[20:16];
    assign rd     = head[15:11];
    assign shamt  = head[10:6];
    assign funct  = head[5:0];
    assign imm    = head[15:0];

    // Operand reads straight from the head entry
    assign raddr_a = rs;
    assign raddr_b = rt;

    always_comb
    begin
        legal   = 1'b1;
        op      = ALU_ADD;
        dest    = rt;
        use_imm = 1'b1;
        // Sign extension for ADDI only
        imm_ext = {16'h0000, imm};
        case (opcode)
            OPC_RTYPE:
            begin
                dest    = rd;
                use_imm = 1'b0;
                case (funct)
                    FN_ADD:  op = ALU_ADD;
                    FN_SUB:  op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLL:  op = ALU_SLL;
                    FN_SRL:  op = ALU_SRL;
                    default: legal = 1'b0;
                endcase
            end
            OPC_ADDI:
            begin
                op      = ALU_ADD;
                imm_ext = {{16{imm[15]}}, imm};
            end
            OPC_ANDI: op = ALU_AND;
            OPC_ORI:  op = ALU_OR;
            OPC_XORI: op = ALU_XOR;
            OPC_LUI:  op = ALU_LUI;
            default:  legal = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operand select and decode register
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        dec_next.valid     = pop && legal;
        dec_next.op        = op;
        dec_next.dest      = dest;
        dec_next.shamt     = shamt;
        dec_next.operand_a = fwd_pick(rs, rdata_a, exe_fwd, res_fwd);
        dec_next.operand_b = use_imm ? imm_ext : fwd_pick(rt, rdata_b, exe_fwd, res_fwd);
        // Instruction just ahead still in flight, execute takes its result
        dec_next.fwd_a     = dec_out.valid && (dec_out.dest != '0) && (dec_out.dest == rs);
        dec_next.fwd_b     = !use_imm && dec_out.valid && (dec_out.dest != '0)
                             && (dec_out.dest == rt);
    end

    // Bubble when nothing popped or the encoding is unknown
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dec_out <= '0;
        else
            dec_out <= dec_next;
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ns

module register_file
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Write port from the result stage
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0]     wdata,
    // Operand read ports
    input  logic [REG_ADDR_W-1:0] raddr_a,
    input  logic [REG_ADDR_W-1:0] raddr_b,
    output logic [DATA_W-1:0]     rdata_a,
    output logic [DATA_W-1:0]     rdata_b,
    // Debug read port
    input  logic                  dbg_on,
    input  logic [REG_ADDR_W-1:0] dbg_addr,
    output logic [DATA_W-1:0]     dbg_data
);

    // 32 x 32 array
    logic [DATA_W-1:0] regs [NUM_REGS];

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    // All registers clear on reset
    // Register 0 is never written
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    // Operand reads, combinational
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // Debug read, sampled only in debug mode
    // Holds the last value otherwise
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dbg_data <= '0;
        end
        else if (dbg_on)
        begin
            dbg_data <= (dbg_addr == '0) ? '0 : regs[dbg_addr];
        end
    end

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    localparam int DATA_W          = 32;
    localparam int INSTR_W         = 32;
    localparam int REG_ADDR_W      = 5;
    localparam int NUM_REGS        = 32;

    // Buffer entries, also the credits owned after reset
    localparam int INSTR_BUF_DEPTH = 4;
    localparam int CREDIT_CNT_W    = 3;
    localparam int BUF_PTR_W       = 2;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // Primary opcodes
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_ANDI  = 6'h0C;
    localparam logic [5:0] OPC_ORI   = 6'h0D;
    localparam logic [5:0] OPC_XORI  = 6'h0E;
    localparam logic [5:0] OPC_LUI   = 6'h0F;

    // R-type function field
    localparam logic [5:0] FN_SLL    = 6'h00;
    localparam logic [5:0] FN_SRL    = 6'h02;
    localparam logic [5:0] FN_ADD    = 6'h20;
    localparam logic [5:0] FN_SUB    = 6'h22;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_XOR    = 6'h26;
    localparam logic [5:0] FN_SLT    = 6'h2A;

    ////////////////////////////////////////////////////////////
    // Stage types
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Decode to execute
    // fwd_a and fwd_b take the operand from the instruction just ahead
    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     operand_a;
        logic [DATA_W-1:0]     operand_b;
        logic [4:0]            shamt;
        logic                  fwd_a;
        logic                  fwd_b;
    } dec_op_t;

    // Execute to result, result to retire
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     data;
    } wb_t;

endpackage
